/* flist.f */
verilog/isaPkg.sv
verilog/datapathPkg.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/memoryInterface.sv
verilog/wordMemory.sv
verilog/srcDatapath.sv
tb/srcDatapathAsserts.sv
tb/srcDatapathTb.sv

/* run.sh */
#!/bin/sh
# build and run the datapath testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module srcDatapathTb \
    -f flist.f -o srcDatapathSim

./obj_dir/srcDatapathSim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* tb/srcDatapathTb.sv */
`timescale 1ns/1ps
`default_nettype none

module srcDatapathTb;

    localparam int OP_COUNT    = 34;                // instructions plus data accesses
    localparam int CYCLE_LIMIT = 40 * OP_COUNT;
    localparam logic [2:0] SEL_RB = 3'b010;         // {gra, grb, grc}
    localparam logic [2:0] SEL_RC = 3'b001;

    logic                               clock = 1'b0;
    logic                               reset;
    datapathPkg::controlWord            control;
    logic [datapathPkg::DATA_WIDTH-1:0] inPortData;
    logic [datapathPkg::DATA_WIDTH-1:0] outPortData;
    logic                               memDone;

    logic [31:0] regModel [16];                     // r0..r15 as the program sees them
    logic [31:0] memModel [512];
    logic [31:0] pcModel;
    logic [31:0] rngState = 32'd8;                  // xorshift seed
    logic [4:0]  aluOps [8] = '{isaPkg::ALU_ADD, isaPkg::ALU_SUB, isaPkg::ALU_AND,
                                isaPkg::ALU_OR, isaPkg::ALU_SHL, isaPkg::ALU_SHR,
                                isaPkg::ALU_NEG, isaPkg::ALU_NOT};
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    srcDatapath uut (
        .clock(clock), .reset(reset), .control(control),
        .inPortData(inPortData), .outPortData(outPortData), .memDone(memDone)
    );

    always #2 clock = ~clock;                       // 4 ns period

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a memory access never finished", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // 32-bit result of the register ALU ops, Y op bus
    function automatic logic [31:0] aluModel(input logic [4:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            isaPkg::ALU_ADD: return a + b;
            isaPkg::ALU_SUB: return a - b;
            isaPkg::ALU_AND: return a & b;
            isaPkg::ALU_OR:  return a | b;
            isaPkg::ALU_SHL: return a << b[4:0];    // count from the low 5 bits
            isaPkg::ALU_SHR: return a >> b[4:0];    // zero fill
            isaPkg::ALU_NEG: return 32'd0 - b;      // unary on the bus
            isaPkg::ALU_NOT: return ~b;
            default:         return 32'd0;
        endcase
    endfunction

    // one control word for one clock, inputs change 1 ns after the edge
    task automatic apply(input datapathPkg::controlWord w);
        control = w;
        @(posedge clock);
        #1;
    endtask

    task automatic checkOut(input string name, input logic [31:0] expected);
        checks++;
        if (outPortData !== expected) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, outPortData);
        end
    endtask

    task automatic memoryAccess(input logic write);
        apply('{memRead: !write, memWrite: write, default: '0});  // start pulse
        control = '0;
        while (!memDone) begin                     // latency set by the memory
            @(posedge clock);
            #1;
        end
    endtask

    task automatic writeMemory(input logic [8:0] addr, input logic [31:0] data);
        inPortData = {23'd0, addr};
        apply('{busSource: datapathPkg::SRC_INPORT, marLoad: 1'b1, default: '0});
        inPortData = data;
        apply('{busSource: datapathPkg::SRC_INPORT, mdrLoad: 1'b1, default: '0});
        memoryAccess(1'b1);
        memModel[addr] = data;
    endtask

    task automatic readMemory(input logic [8:0] addr);
        inPortData = {23'd0, addr};
        apply('{busSource: datapathPkg::SRC_INPORT, marLoad: 1'b1, default: '0});
        memoryAccess(1'b0);
        apply('{busSource: datapathPkg::SRC_MDR, outPortLoad: 1'b1, default: '0});
        checkOut("memory load", memModel[addr]);
    endtask

    // store the word at PC, then T0..T2 of the fetch and a look at PC
    task automatic fetch(input logic [31:0] instr);
        writeMemory(pcModel[8:0], instr);
        inPortData = ~instr;                        // MDR holds another word before the read
        apply('{busSource: datapathPkg::SRC_INPORT, mdrLoad: 1'b1, default: '0});
        apply('{busSource: datapathPkg::SRC_PC, marLoad: 1'b1, zLoad: 1'b1,
                aluOp: isaPkg::ALU_INC, default: '0});
        apply('{busSource: datapathPkg::SRC_ZLO, pcLoad: 1'b1, default: '0});
        memoryAccess(1'b0);
        apply('{busSource: datapathPkg::SRC_MDR, irLoad: 1'b1, default: '0});
        pcModel = pcModel + 32'd1;
        apply('{busSource: datapathPkg::SRC_PC, outPortLoad: 1'b1, default: '0});
        checkOut("pc increment", pcModel);
    endtask

    task automatic loadRegister(input logic [2:0] sel, input logic [3:0] index,
                                input logic [31:0] value);
        inPortData = value;
        apply('{busSource: datapathPkg::SRC_INPORT, regLoad: 1'b1, gra: sel[2],
                grb: sel[1], grc: sel[0], default: '0});
        regModel[index] = value;
    endtask

    task automatic showRegister(input string name, input logic [3:0] ra);
        apply('{busSource: datapathPkg::SRC_REG, gra: 1'b1, outPortLoad: 1'b1, default: '0});
        checkOut(name, regModel[ra]);
    endtask

    initial begin
        isaPkg::instrWord   instr;
        logic [31:0]        a;
        logic [18:0]        c;
        logic signed [63:0] product;
        logic [8:0]         addrs [8];

        control    = '0;
        inPortData = '0;
        reset      = 1'b1;
        pcModel    = '0;
        for (int i = 0; i < 16; i++) regModel[i] = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        apply('{busSource: datapathPkg::SRC_PC, outPortLoad: 1'b1, default: '0});
        checkOut("pc after reset", 32'd0);

        // mflo and mfhi, value in through LO or HI and out through ra
        for (int i = 0; i < 4; i++) begin
            a = nextRandom();
            inPortData = a;
            apply('{busSource: datapathPkg::SRC_INPORT, loLoad: !i[0], hiLoad: i[0],
                    default: '0});
            instr = '0;
            instr.regFormat.ra = a[3:0];
            fetch(instr);
            apply('{busSource: i[0] ? datapathPkg::SRC_HI : datapathPkg::SRC_LO,
                    gra: 1'b1, regLoad: 1'b1, default: '0});
            regModel[instr.regFormat.ra] = a;
            showRegister("move from hi/lo", instr.regFormat.ra);
        end

        // three-register ALU ops, aliasing of ra/rb/rc allowed
        for (int i = 0; i < 8; i++) begin
            a = nextRandom();
            instr = '0;
            instr.regFormat.opcode = aluOps[a[2:0]];
            instr.regFormat.ra     = a[7:4];
            instr.regFormat.rb     = a[11:8];
            instr.regFormat.rc     = a[15:12];
            fetch(instr);
            loadRegister(SEL_RB, instr.regFormat.rb, nextRandom());
            loadRegister(SEL_RC, instr.regFormat.rc, nextRandom());
            apply('{busSource: datapathPkg::SRC_REG, grb: 1'b1, yLoad: 1'b1, default: '0});
            apply('{busSource: datapathPkg::SRC_REG, grc: 1'b1, zLoad: 1'b1,
                    aluOp: instr.regFormat.opcode, default: '0});
            apply('{busSource: datapathPkg::SRC_ZLO, gra: 1'b1, regLoad: 1'b1, default: '0});
            regModel[instr.regFormat.ra] = aluModel(instr.regFormat.opcode,
                regModel[instr.regFormat.rb], regModel[instr.regFormat.rc]);
            showRegister($sformatf("alu op %b", instr.regFormat.opcode), instr.regFormat.ra);
        end

        // mul into HI and LO, each half routed out
        for (int i = 0; i < 2; i++) begin
            a = nextRandom();
            instr = '0;
            instr.regFormat.opcode = isaPkg::ALU_MUL;
            instr.regFormat.rb     = a[3:0];
            instr.regFormat.rc     = a[7:4];
            fetch(instr);
            loadRegister(SEL_RB, instr.regFormat.rb, nextRandom());
            loadRegister(SEL_RC, instr.regFormat.rc, nextRandom());
            apply('{busSource: datapathPkg::SRC_REG, grb: 1'b1, yLoad: 1'b1, default: '0});
            apply('{busSource: datapathPkg::SRC_REG, grc: 1'b1, zLoad: 1'b1,
                    aluOp: isaPkg::ALU_MUL, default: '0});
            apply('{busSource: datapathPkg::SRC_ZLO, loLoad: 1'b1, default: '0});
            apply('{busSource: datapathPkg::SRC_ZHI, hiLoad: 1'b1, default: '0});
            product = 64'($signed(regModel[instr.regFormat.rb])) *
                      64'($signed(regModel[instr.regFormat.rc]));
            apply('{busSource: datapathPkg::SRC_LO, outPortLoad: 1'b1, default: '0});
            checkOut("mul lo", product[31:0]);
            apply('{busSource: datapathPkg::SRC_HI, outPortLoad: 1'b1, default: '0});
            checkOut("mul hi", product[63:32]);
        end

        // addi, sign alternates, last two use r0 as base with baOut
        for (int i = 0; i < 4; i++) begin
            a = nextRandom();
            c = a[18:0];
            c[18] = i[0];
            instr = '0;
            instr.immFormat.ra       = a[31:28];
            instr.immFormat.rb       = i[1] ? 4'd0 : a[27:24];
            instr.immFormat.constant = c;
            fetch(instr);
            loadRegister(SEL_RB, instr.immFormat.rb, nextRandom());  // r0 value is hidden
            apply('{busSource: datapathPkg::SRC_REG, grb: 1'b1, baOut: i[1], yLoad: 1'b1,
                    default: '0});
            apply('{busSource: datapathPkg::SRC_CONST, zLoad: 1'b1, aluOp: isaPkg::ALU_ADD,
                    default: '0});
            apply('{busSource: datapathPkg::SRC_ZLO, gra: 1'b1, regLoad: 1'b1, default: '0});
            regModel[instr.immFormat.ra] = (i[1] ? 32'd0 : regModel[instr.immFormat.rb]) +
                                           {{13{c[18]}}, c};
            showRegister("add immediate", instr.immFormat.ra);
        end

        // data in the upper half, clear of the program words
        for (int i = 0; i < 8; i++) begin
            a = nextRandom();
            addrs[i] = {1'b1, a[7:0]};
            writeMemory(addrs[i], nextRandom());
        end
        // scattered order, first load is not the last store
        for (int i = 0; i < 8; i++) readMemory(addrs[(i * 3 + 1) % 8]);

        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 uut.memIf.memChecks.failures);
        if (errors == 0 && uut.memIf.memChecks.failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/srcDatapathAsserts.sv */
`timescale 1ns/1ps
`default_nettype none

module srcDatapathAsserts (
    input logic                    clock,
    input logic                    reset,
    input datapathPkg::controlWord control,
    input logic                    memReq,
    input logic                    memAck,
    input logic                    memDone
);

    int   failures = 0;    // failed properties so far
    logic startPulse;      // read or write request from the control word

    assign startPulse = control.memRead | control.memWrite;

    reqHeld: assert property (@(posedge clock) disable iff (reset)
        memReq && !memAck |=> memReq)
        else begin failures++; $error("memReq dropped before memAck"); end

    ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
        $rose(memAck) |-> memReq)
        else begin failures++; $error("memAck rose with no request"); end

    doneOneCycle: assert property (@(posedge clock) disable iff (reset)
        $fell(memAck) |=> memDone ##1 !memDone)
        else begin failures++; $error("memDone not a single pulse after memAck fell"); end

    startWhenIdle: assert property (@(posedge clock) disable iff (reset)
        startPulse |-> !memReq && !memAck)
        else begin failures++; $error("memory start pulse during a busy handshake"); end

endmodule

bind memoryInterface srcDatapathAsserts memChecks (
    .clock(clock), .reset(reset), .control(control),
    .memReq(memReq), .memAck(memAck), .memDone(memDone)
);

`default_nettype wire

/* verilog/srcDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module srcDatapath (
    input  logic                                clock,
    input  logic                                reset,
    input  datapathPkg::controlWord             control,
    input  logic [datapathPkg::DATA_WIDTH-1:0]  inPortData,
    output logic [datapathPkg::DATA_WIDTH-1:0]  outPortData,
    output logic                                memDone
);

    logic [datapathPkg::DATA_WIDTH-1:0]     busValue;      // the shared bus
    logic [datapathPkg::DATA_WIDTH-1:0]     pc;
    isaPkg::instrWord                       ir;
    logic [datapathPkg::DATA_WIDTH-1:0]     y;
    logic [2*datapathPkg::DATA_WIDTH-1:0]   z;
    logic [datapathPkg::DATA_WIDTH-1:0]     hi;
    logic [datapathPkg::DATA_WIDTH-1:0]     lo;
    logic [datapathPkg::DATA_WIDTH-1:0]     regOut;        // register file read
    logic [datapathPkg::DATA_WIDTH-1:0]     mdrValue;
    logic [datapathPkg::DATA_WIDTH-1:0]     constValue;    // C sign-extended
    logic [2*datapathPkg::DATA_WIDTH-1:0]   aluResult;
    logic                                   memReq;
    logic                                   memWe;
    logic                                   memAck;
    logic [datapathPkg::MEM_ADDR_WIDTH-1:0] memAddr;
    logic [datapathPkg::DATA_WIDTH-1:0]     memWData;
    logic [datapathPkg::DATA_WIDTH-1:0]     memRData;

    assign constValue = {{(datapathPkg::DATA_WIDTH - isaPkg::CONST_WIDTH)
                          {ir.immFormat.constant[isaPkg::CONST_WIDTH-1]}},
                         ir.immFormat.constant};

    always_comb begin
        case (control.busSource)
            datapathPkg::SRC_REG:    busValue = regOut;
            datapathPkg::SRC_PC:     busValue = pc;
            datapathPkg::SRC_MDR:    busValue = mdrValue;
            datapathPkg::SRC_ZLO:    busValue = z[datapathPkg::DATA_WIDTH-1:0];
            datapathPkg::SRC_ZHI:    busValue = z[2*datapathPkg::DATA_WIDTH-1:datapathPkg::DATA_WIDTH];
            datapathPkg::SRC_HI:     busValue = hi;
            datapathPkg::SRC_LO:     busValue = lo;
            datapathPkg::SRC_INPORT: busValue = inPortData;   // input port is unlatched
            datapathPkg::SRC_CONST:  busValue = constValue;
            datapathPkg::SRC_NONE:   busValue = '0;
            default:                 busValue = '0;           // idle bus
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc          <= '0;
            ir          <= '0;
            y           <= '0;
            z           <= '0;
            hi          <= '0;
            lo          <= '0;
            outPortData <= '0;
        end else begin
            if (control.pcLoad)      pc          <= busValue;   // usually Z low after inc
            if (control.irLoad)      ir          <= busValue;   // from MDR at fetch
            if (control.yLoad)       y           <= busValue;
            if (control.zLoad)       z           <= aluResult;
            if (control.hiLoad)      hi          <= busValue;
            if (control.loLoad)      lo          <= busValue;
            if (control.outPortLoad) outPortData <= busValue;
        end
    end

    registerFile regs (
        .clock(clock), .reset(reset), .ir(ir),
        .gra(control.gra), .grb(control.grb), .grc(control.grc),
        .regLoad(control.regLoad), .baOut(control.baOut),
        .busIn(busValue), .regOut(regOut)
    );

    alu aluUnit (.aluOp(control.aluOp), .yValue(y), .busValue(busValue), .result(aluResult));

    memoryInterface memIf (
        .clock(clock), .reset(reset), .control(control), .busIn(busValue),
        .mdrValue(mdrValue), .memReq(memReq), .memWe(memWe), .memAddr(memAddr),
        .memWData(memWData), .memAck(memAck), .memRData(memRData), .memDone(memDone)
    );

    wordMemory mem (
        .clock(clock), .reset(reset), .memReq(memReq), .memWe(memWe),
        .memAddr(memAddr), .memWData(memWData), .memAck(memAck), .memRData(memRData)
    );

endmodule

`default_nettype wire

/* verilog/wordMemory.sv */
`timescale 1ns/1ps
`default_nettype none

module wordMemory (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    memReq,
    input  logic                                    memWe,
    input  logic [datapathPkg::MEM_ADDR_WIDTH-1:0]  memAddr,
    input  logic [datapathPkg::DATA_WIDTH-1:0]      memWData,
    output logic                                    memAck,
    output logic [datapathPkg::DATA_WIDTH-1:0]      memRData
);

    logic [datapathPkg::DATA_WIDTH-1:0]      mem [datapathPkg::MEM_WORDS];
    logic [datapathPkg::LFSR_WIDTH-1:0]      lfsr;       // x^4 + x^3 + 1
    logic                                    waiting;    // request seen, counting
    logic [datapathPkg::ACK_DELAY_WIDTH-1:0] waitCount;
    logic                                    ackNow;     // access happens this edge

    assign ackNow = waiting && waitCount == '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr      <= datapathPkg::LFSR_SEED;
            memAck    <= 1'b0;
            waiting   <= 1'b0;
            waitCount <= '0;
        end else begin
            lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};               // free running
            if (memAck) begin
                if (!memReq) memAck <= 1'b0;                      // phase 4
            end else if (waiting) begin
                if (ackNow) begin
                    memAck  <= 1'b1;                              // phase 2
                    waiting <= 1'b0;
                end else begin
                    waitCount <= waitCount - 1'b1;
                end
            end else if (memReq) begin
                waiting   <= 1'b1;
                waitCount <= lfsr[datapathPkg::ACK_DELAY_WIDTH-1:0];  // 1..4 cycles to ack
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ackNow) begin
            if (memWe) mem[memAddr] <= memWData;
            memRData <= mem[memAddr];                             // old word on a write
        end
    end

endmodule

`default_nettype wire

/* verilog/memoryInterface.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryInterface (
    input  logic                                    clock,
    input  logic                                    reset,
    input  datapathPkg::controlWord                 control,
    input  logic [datapathPkg::DATA_WIDTH-1:0]      busIn,
    output logic [datapathPkg::DATA_WIDTH-1:0]      mdrValue,
    output logic                                    memReq,
    output logic                                    memWe,
    output logic [datapathPkg::MEM_ADDR_WIDTH-1:0]  memAddr,
    output logic [datapathPkg::DATA_WIDTH-1:0]      memWData,
    input  logic                                    memAck,
    input  logic [datapathPkg::DATA_WIDTH-1:0]      memRData,
    output logic                                    memDone
);

    logic [1:0]                               state;
    logic [datapathPkg::MEM_ADDR_WIDTH-1:0]   mar;
    logic [datapathPkg::DATA_WIDTH-1:0]       mdr;
    logic                                     start;   // accepted start pulse

    // pulses during a busy handshake are dropped
    assign start    = (control.memRead | control.memWrite) &&
                      state == datapathPkg::MEM_IDLE && !memAck;
    assign mdrValue = mdr;

    always_ff @(posedge clock) begin
        if (reset) begin
            state   <= datapathPkg::MEM_IDLE;
            memReq  <= 1'b0;
            memWe   <= 1'b0;
            memDone <= 1'b0;
            mar     <= '0;
            mdr     <= '0;
        end else begin
            memDone <= 1'b0;                                      // one-cycle pulse
            if (control.marLoad) mar <= busIn[datapathPkg::MEM_ADDR_WIDTH-1:0];
            if (control.mdrLoad) mdr <= busIn;
            case (state)
                datapathPkg::MEM_IDLE: if (start) begin
                    memReq <= 1'b1;                               // phase 1
                    memWe  <= control.memWrite;                   // write wins if both
                    state  <= datapathPkg::MEM_REQ;
                end
                datapathPkg::MEM_REQ: if (memAck) begin
                    if (!memWe) mdr <= memRData;                  // read data into MDR
                    memReq <= 1'b0;                               // phase 3
                    state  <= datapathPkg::MEM_RELEASE;
                end
                datapathPkg::MEM_RELEASE: if (!memAck) begin
                    memWe   <= 1'b0;
                    memDone <= 1'b1;                              // phase 5
                    state   <= datapathPkg::MEM_IDLE;
                end
                default: state <= datapathPkg::MEM_IDLE;
            endcase
        end
    end

    // address and data frozen for the whole request
    always_ff @(posedge clock) begin
        if (start) begin
            memAddr  <= mar;
            memWData <= mdr;
        end
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [isaPkg::ALU_OP_WIDTH-1:0]      aluOp,
    input  logic [datapathPkg::DATA_WIDTH-1:0]   yValue,    // first operand, from Y
    input  logic [datapathPkg::DATA_WIDTH-1:0]   busValue,  // second operand
    output logic [2*datapathPkg::DATA_WIDTH-1:0] result     // goes to Z
);

    logic signed [2*datapathPkg::DATA_WIDTH-1:0] product;  // full signed mul
    logic [datapathPkg::DATA_WIDTH-1:0]          low;      // 32-bit result
    logic                                        extend;   // sign-extend low word
    logic [datapathPkg::SHIFT_WIDTH-1:0]         shamt;

    assign shamt   = busValue[datapathPkg::SHIFT_WIDTH-1:0];
    assign product = $signed(yValue) * $signed(busValue);

    always_comb begin
        low    = '0;
        extend = 1'b0;
        case (aluOp)
            isaPkg::ALU_ADD: begin
                low    = yValue + busValue;
                extend = 1'b1;
            end
            isaPkg::ALU_SUB: begin
                low    = yValue - busValue;
                extend = 1'b1;
            end
            isaPkg::ALU_AND: low = yValue & busValue;
            isaPkg::ALU_OR:  low = yValue | busValue;
            isaPkg::ALU_SHL: low = yValue << shamt;
            isaPkg::ALU_SHR: low = yValue >> shamt;   // logical shift
            isaPkg::ALU_NEG: begin
                low    = '0 - busValue;               // unary, bus only
                extend = 1'b1;
            end
            isaPkg::ALU_NOT: low = ~busValue;
            isaPkg::ALU_INC: low = busValue + 32'd1;  // pc + 1 through the bus
            isaPkg::ALU_NOP: low = '0;
            default:         low = '0;                // mul handled below
        endcase
    end

    // mul fills both halves for HI/LO, the rest carry a 32-bit result
    assign result = (aluOp == isaPkg::ALU_MUL) ? product
                  : {{datapathPkg::DATA_WIDTH{extend & low[datapathPkg::DATA_WIDTH-1]}}, low};

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                                clock,
    input  logic                                reset,
    input  isaPkg::instrWord                    ir,
    input  logic                                gra,
    input  logic                                grb,
    input  logic                                grc,
    input  logic                                regLoad,
    input  logic                                baOut,
    input  logic [datapathPkg::DATA_WIDTH-1:0]  busIn,
    output logic [datapathPkg::DATA_WIDTH-1:0]  regOut
);

    logic [datapathPkg::DATA_WIDTH-1:0] regs [isaPkg::REG_COUNT];  // r0..r15
    logic [isaPkg::REG_FIELD_WIDTH-1:0] select;                    // chosen entry

    // ra/rb/rc sit at the same place in both formats
    always_comb begin
        if (gra) begin
            select = ir.regFormat.ra;
        end else if (grb) begin
            select = ir.regFormat.rb;
        end else if (grc) begin
            select = ir.regFormat.rc;
        end else begin
            select = '0;                  // nothing selected, point at r0
        end
    end

    // base-address read, r0 gives zero so ld/st/addi see plain C
    assign regOut = (baOut && select == '0) ? '0 : regs[select];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < isaPkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regLoad) begin
            regs[select] <= busIn;        // write port shares the read select
        end
    end

endmodule

`default_nettype wire

/* verilog/datapathPkg.sv */
`default_nettype none

package datapathPkg;

    localparam int DATA_WIDTH      = 32;
    localparam int SHIFT_WIDTH     = 5;       // shift amount bits taken from bus
    localparam int MEM_WORDS       = 512;
    localparam int MEM_ADDR_WIDTH  = 9;
    localparam int LFSR_WIDTH      = 4;       // ack delay generator
    localparam int ACK_DELAY_WIDTH = 2;       // delay 0..3 extra cycles
    localparam logic [LFSR_WIDTH-1:0] LFSR_SEED = 4'b1001;  // any nonzero value

    // bus source select, one code so only one driver at a time
    localparam logic [3:0] SRC_REG    = 4'd0;
    localparam logic [3:0] SRC_PC     = 4'd1;
    localparam logic [3:0] SRC_MDR    = 4'd2;
    localparam logic [3:0] SRC_ZLO    = 4'd3;
    localparam logic [3:0] SRC_ZHI    = 4'd4;
    localparam logic [3:0] SRC_HI     = 4'd5;
    localparam logic [3:0] SRC_LO     = 4'd6;
    localparam logic [3:0] SRC_INPORT = 4'd7;
    localparam logic [3:0] SRC_CONST  = 4'd8;   // sign-extended C field
    localparam logic [3:0] SRC_NONE   = 4'd15;

    // memory requester states
    localparam logic [1:0] MEM_IDLE    = 2'd0;
    localparam logic [1:0] MEM_REQ     = 2'd1;   // req high, waiting for ack
    localparam logic [1:0] MEM_RELEASE = 2'd2;   // req dropped, waiting for ack low

    typedef struct packed {
        logic [3:0] busSource;
        logic       gra;          // select by ra
        logic       grb;          // select by rb
        logic       grc;          // select by rc
        logic       regLoad;
        logic       baOut;        // r0 reads zero
        logic       pcLoad;
        logic       irLoad;
        logic       yLoad;
        logic       zLoad;        // z takes alu result
        logic       hiLoad;
        logic       loLoad;
        logic       marLoad;
        logic       mdrLoad;
        logic       outPortLoad;
        logic       memRead;      // start pulse
        logic       memWrite;     // start pulse
        logic [isaPkg::ALU_OP_WIDTH-1:0] aluOp;
    } controlWord;

endpackage

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int OPCODE_WIDTH    = 5;                     // major opcode field
    localparam int REG_FIELD_WIDTH = 4;                     // ra, rb, rc select
    localparam int CONST_WIDTH     = 19;                    // immediate constant C
    localparam int UNUSED_WIDTH    = 15;                    // pad of register format
    localparam int REG_COUNT       = 1 << REG_FIELD_WIDTH;  // general registers
    localparam int ALU_OP_WIDTH    = 5;

    // alu codes follow the opcodes of the instruction set
    localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD = 5'b00011;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB = 5'b00100;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_AND = 5'b00101;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_OR  = 5'b00110;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SHR = 5'b00111;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_SHL = 5'b01001;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_MUL = 5'b01111;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_NEG = 5'b10001;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_NOT = 5'b10010;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_NOP = 5'b11010;
    localparam logic [ALU_OP_WIDTH-1:0] ALU_INC = 5'b11100;  // pc increment, no opcode

    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]    opcode;
        logic [REG_FIELD_WIDTH-1:0] ra;      // destination
        logic [REG_FIELD_WIDTH-1:0] rb;      // first source
        logic [REG_FIELD_WIDTH-1:0] rc;      // second source
        logic [UNUSED_WIDTH-1:0]    unused;
    } regFields;

    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]    opcode;
        logic [REG_FIELD_WIDTH-1:0] ra;
        logic [REG_FIELD_WIDTH-1:0] rb;      // base or source
        logic [CONST_WIDTH-1:0]     constant; // two's complement
    } immFields;

    typedef union packed {
        regFields regFormat;    // three-register instructions
        immFields immFormat;    // register plus constant
    } instrWord;

endpackage

`default_nettype wire
